//--- run.sh
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator and run it.
# The simulation exits with a failing status on any $fatal.

set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module mem_subsys_tb \
    -Mdir obj_dir

./obj_dir/Vmem_subsys_tb

//--- source/main_mem.sv
`timescale 1ns/1ps
`default_nettype none

module main_mem (
    input  logic                     clk,
    input  logic                     rst_n,

    // Request from the arbiter
    input  mem_types_pkg::mem_req_t  mem_req,

    // Tagged read response, MEM_LATENCY cycles later
    output mem_types_pkg::mem_resp_t mem_resp
);

    import mem_cfg_pkg::*;
    import mem_types_pkg::*;

    // Block storage, contents are not reset
    block_data_t mem_array [MEM_DEPTH];

    // Response pipeline, stage 0 is where the array is accessed
    logic        valid_q [MEM_LATENCY];
    cache_type_t tag_q   [MEM_LATENCY];
    block_data_t data_q  [MEM_LATENCY];

    logic is_read;
    logic is_write;

    always_comb begin
        is_read  = mem_req.valid && (mem_req.req_type == READ);
        is_write = mem_req.valid && (mem_req.req_type == WRITE);
    end

    // Array access in the first stage, remaining stages carry tag and data along
    // Requests arrive one per cycle, so a read right after a write sees the new block
    always_ff @(posedge clk) begin
        if (is_write) begin
            mem_array[mem_req.block_addr] <= mem_req.block_data;
        end
        if (is_read) begin
            data_q[0] <= mem_array[mem_req.block_addr];
            tag_q[0]  <= mem_req.cache_type;
        end
        for (int i = 1; i < MEM_LATENCY; i++) begin
            tag_q[i]  <= tag_q[i-1];
            data_q[i] <= data_q[i-1];
        end
    end

    // Only reads enter the pipeline
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_LATENCY; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            valid_q[0] <= is_read;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Last stage drives the response
    always_comb begin
        mem_resp.valid      = valid_q[MEM_LATENCY-1];
        mem_resp.cache_type = tag_q[MEM_LATENCY-1];
        mem_resp.block_data = data_q[MEM_LATENCY-1];
    end

endmodule

`default_nettype wire

//--- source/mem_cfg_pkg.sv
`default_nettype none

package mem_cfg_pkg;

    // Block addressing, 64 blocks of 128 bits
    localparam int BLOCK_ADDR_BITS = 6;
    localparam int BLOCK_BITS      = 128;
    localparam int MEM_DEPTH       = 1 << BLOCK_ADDR_BITS;

    // Register stages inside main_mem
    localparam int MEM_LATENCY = 3;

    // Accepting edge to response strobe
    // One arbiter register, the memory stages, one router register
    localparam int RESP_LATENCY = MEM_LATENCY + 2;

endpackage

`default_nettype wire

//--- source/mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,

    // Icache request, always a read
    input  logic                                icache_req_valid,
    input  mem_types_pkg::main_mem_block_addr_t icache_req_block_addr,
    output logic                                icache_req_ready,

    // Dcache request
    input  logic                                dcache_req_valid,
    input  mem_types_pkg::req_type_t            dcache_req_type,
    input  mem_types_pkg::main_mem_block_addr_t dcache_req_block_addr,
    input  mem_types_pkg::block_data_t          dcache_req_block_data,
    output logic                                dcache_req_ready,

    // Registered request towards main_mem
    output mem_types_pkg::mem_req_t             mem_req
);

    import mem_types_pkg::*;

    mem_req_t req_d;

    // Icache has fixed priority, ready doubles as the grant
    always_comb begin
        icache_req_ready = icache_req_valid;
        dcache_req_ready = dcache_req_valid && !icache_req_valid;
    end

    // Select the winning request
    always_comb begin
        req_d = '0;
        if (icache_req_valid) begin
            req_d.valid      = 1'b1;
            req_d.cache_type = ICACHE;
            req_d.req_type   = READ;
            req_d.block_addr = icache_req_block_addr;
        end else if (dcache_req_valid) begin
            req_d.valid      = 1'b1;
            req_d.cache_type = DCACHE;
            req_d.req_type   = dcache_req_type;
            req_d.block_addr = dcache_req_block_addr;
            // Data only travels with writes
            if (dcache_req_type == WRITE) begin
                req_d.block_data = dcache_req_block_data;
            end
        end
    end

    // Granted request appears one cycle after the accepting edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_req <= '0;
        end else begin
            mem_req <= req_d;    // All zero when idle
        end
    end

endmodule

`default_nettype wire

//--- source/mem_resp_router.sv
`timescale 1ns/1ps
`default_nettype none

module mem_resp_router (
    input  logic                       clk,
    input  logic                       rst_n,

    // Tagged response from main_mem
    input  mem_types_pkg::mem_resp_t   mem_resp,

    // Per cache response ports
    output logic                       icache_resp_valid,
    output mem_types_pkg::block_data_t icache_resp_block_data,
    output logic                       dcache_resp_valid,
    output mem_types_pkg::block_data_t dcache_resp_block_data
);

    import mem_types_pkg::*;

    logic to_icache;
    logic to_dcache;

    // Decode the tag
    always_comb begin
        to_icache = mem_resp.valid && (mem_resp.cache_type == ICACHE);
        to_dcache = mem_resp.valid && (mem_resp.cache_type == DCACHE);
    end

    // One cycle strobes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            icache_resp_valid <= 1'b0;
            dcache_resp_valid <= 1'b0;
        end else begin
            icache_resp_valid <= to_icache;
            dcache_resp_valid <= to_dcache;
        end
    end

    // Data holds between strobes
    always_ff @(posedge clk) begin
        if (to_icache) icache_resp_block_data <= mem_resp.block_data;
        if (to_dcache) dcache_resp_block_data <= mem_resp.block_data;
    end

endmodule

`default_nettype wire

//--- source/mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys (
    input  logic                                clk,
    input  logic                                rst_n,

    // Icache request
    input  logic                                icache_req_valid,
    input  mem_types_pkg::main_mem_block_addr_t icache_req_block_addr,
    output logic                                icache_req_ready,

    // Dcache request
    input  logic                                dcache_req_valid,
    input  mem_types_pkg::req_type_t            dcache_req_type,
    input  mem_types_pkg::main_mem_block_addr_t dcache_req_block_addr,
    input  mem_types_pkg::block_data_t          dcache_req_block_data,
    output logic                                dcache_req_ready,

    // Icache response
    output logic                                icache_resp_valid,
    output mem_types_pkg::block_data_t          icache_resp_block_data,

    // Dcache response
    output logic                                dcache_resp_valid,
    output mem_types_pkg::block_data_t          dcache_resp_block_data
);

    import mem_types_pkg::*;

    mem_req_t  mem_req;     // Arbiter to memory
    mem_resp_t mem_resp;    // Memory to router

    mem_ctrl u_mem_ctrl (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .icache_req_valid      (icache_req_valid),
        .icache_req_block_addr (icache_req_block_addr),
        .icache_req_ready      (icache_req_ready),
        .dcache_req_valid      (dcache_req_valid),
        .dcache_req_type       (dcache_req_type),
        .dcache_req_block_addr (dcache_req_block_addr),
        .dcache_req_block_data (dcache_req_block_data),
        .dcache_req_ready      (dcache_req_ready),
        .mem_req               (mem_req)
    );

    main_mem u_main_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

    mem_resp_router u_mem_resp_router (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .mem_resp               (mem_resp),
        .icache_resp_valid      (icache_resp_valid),
        .icache_resp_block_data (icache_resp_block_data),
        .dcache_resp_valid      (dcache_resp_valid),
        .dcache_resp_block_data (dcache_resp_block_data)
    );

endmodule

`default_nettype wire

//--- source/mem_types_pkg.sv
`default_nettype none

package mem_types_pkg;

    import mem_cfg_pkg::*;

    typedef logic [BLOCK_ADDR_BITS-1:0] main_mem_block_addr_t;
    typedef logic [BLOCK_BITS-1:0]      block_data_t;

    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1
    } req_type_t;

    // Also the routing tag for responses
    typedef enum logic {
        ICACHE = 1'b0,
        DCACHE = 1'b1
    } cache_type_t;

    // 137 bits
    typedef struct packed {
        logic                 valid;
        cache_type_t          cache_type;
        req_type_t            req_type;
        main_mem_block_addr_t block_addr;
        block_data_t          block_data;   // Only meaningful for writes
    } mem_req_t;

    // 130 bits, reads only
    typedef struct packed {
        logic        valid;
        cache_type_t cache_type;
        block_data_t block_data;
    } mem_resp_t;

endpackage

`default_nettype wire

//--- verification/mem_subsys_chk.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_chk (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     icache_req_valid,
    input  logic                     icache_req_ready,
    input  logic                     dcache_req_valid,
    input  mem_types_pkg::req_type_t dcache_req_type,
    input  logic                     dcache_req_ready,
    input  logic                     icache_resp_valid,
    input  logic                     dcache_resp_valid
);

    import mem_cfg_pkg::*;
    import mem_types_pkg::*;

    logic icache_read_acc;
    logic dcache_read_acc;

    // Reads accepted at this edge
    always_comb begin
        icache_read_acc = icache_req_valid && icache_req_ready;
        dcache_read_acc = dcache_req_valid && dcache_req_ready && (dcache_req_type == READ);
    end

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(icache_req_ready && dcache_req_ready))
        else $error("both request readies are high");

    a_ready_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (!icache_req_ready || icache_req_valid) && (!dcache_req_ready || dcache_req_valid))
        else $error("a ready is high without its valid");

    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(icache_resp_valid && dcache_resp_valid))
        else $error("both response strobes are high");

    // One strobe per accepted read, and none without one
    a_icache_latency: assert property (@(posedge clk) disable iff (!rst_n)
        icache_resp_valid == $past(icache_read_acc, RESP_LATENCY))
        else $error("icache response strobe does not match an accepted read");

    a_dcache_latency: assert property (@(posedge clk) disable iff (!rst_n)
        dcache_resp_valid == $past(dcache_read_acc, RESP_LATENCY))
        else $error("dcache response strobe does not match an accepted read");

endmodule

bind mem_subsys mem_subsys_chk chk0 (
    .clk               (clk),
    .rst_n             (rst_n),
    .icache_req_valid  (icache_req_valid),
    .icache_req_ready  (icache_req_ready),
    .dcache_req_valid  (dcache_req_valid),
    .dcache_req_type   (dcache_req_type),
    .dcache_req_ready  (dcache_req_ready),
    .icache_resp_valid (icache_resp_valid),
    .dcache_resp_valid (dcache_resp_valid)
);

`default_nettype wire

//--- verification/mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb;

    import mem_cfg_pkg::*;
    import mem_types_pkg::*;

    localparam int NUM_ROWS      = 21;
    localparam int HOLD_TIMEOUT  = 8;
    localparam int DRAIN_TIMEOUT = RESP_LATENCY + 4;

    // One row drives one cycle
    typedef struct packed {
        logic                 ic_valid;
        main_mem_block_addr_t ic_addr;
        logic                 dc_valid;
        req_type_t            dc_type;
        main_mem_block_addr_t dc_addr;
        logic                 dc_rand;    // Dcache data from xorshift
    } row_t;

    typedef struct packed {
        cache_type_t tag;
        block_data_t data;
        logic [31:0] due;                 // Edge where the cache samples the strobe
    } exp_resp_t;

    logic                 clk;
    logic                 rst_n;
    logic                 icache_req_valid;
    main_mem_block_addr_t icache_req_block_addr;
    logic                 icache_req_ready;
    logic                 dcache_req_valid;
    req_type_t            dcache_req_type;
    main_mem_block_addr_t dcache_req_block_addr;
    block_data_t          dcache_req_block_data;
    logic                 dcache_req_ready;
    logic                 icache_resp_valid;
    block_data_t          icache_resp_block_data;
    logic                 dcache_resp_valid;
    block_data_t          dcache_resp_block_data;

    row_t        rows [NUM_ROWS];
    block_data_t ref_mem [MEM_DEPTH];    // Reference copy of the block array
    exp_resp_t   exp_q [$];
    logic [31:0] rng_state;
    int          cycle;

    mem_subsys dut0 (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .icache_req_valid       (icache_req_valid),
        .icache_req_block_addr  (icache_req_block_addr),
        .icache_req_ready       (icache_req_ready),
        .dcache_req_valid       (dcache_req_valid),
        .dcache_req_type        (dcache_req_type),
        .dcache_req_block_addr  (dcache_req_block_addr),
        .dcache_req_block_data  (dcache_req_block_data),
        .dcache_req_ready       (dcache_req_ready),
        .icache_resp_valid      (icache_resp_valid),
        .icache_resp_block_data (icache_resp_block_data),
        .dcache_resp_valid      (dcache_resp_valid),
        .dcache_resp_block_data (dcache_resp_block_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_ready(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_resp(input logic exp_valid, input cache_type_t tag,
                              input block_data_t data);
        logic exp_ic;
        logic exp_dc;
        exp_ic = exp_valid && (tag == ICACHE);
        exp_dc = exp_valid && (tag == DCACHE);
        if (icache_resp_valid !== exp_ic) begin
            abort_run($sformatf("FAILED icache_resp_valid: got %h expected %h",
                                icache_resp_valid, exp_ic));
        end else if (dcache_resp_valid !== exp_dc) begin
            abort_run($sformatf("FAILED dcache_resp_valid: got %h expected %h",
                                dcache_resp_valid, exp_dc));
        end else if (exp_ic && (icache_resp_block_data !== data)) begin
            abort_run($sformatf("FAILED icache_resp_block_data: got %h expected %h",
                                icache_resp_block_data, data));
        end else if (exp_dc && (dcache_resp_block_data !== data)) begin
            abort_run($sformatf("FAILED dcache_resp_block_data: got %h expected %h",
                                dcache_resp_block_data, data));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic block_data_t random_block();
        block_data_t blk;
        for (int i = 0; i < BLOCK_BITS / 32; i++) begin
            rng_state = xorshift32(rng_state);
            blk[i*32 +: 32] = rng_state;
        end
        return blk;
    endfunction

    // Model update at the accepting edge
    task automatic record_accept(input row_t row, input block_data_t data,
                                 input logic ic_acc, input logic dc_acc);
        exp_resp_t entry;
        entry.due = cycle + RESP_LATENCY;
        if (ic_acc) begin
            entry.tag  = ICACHE;
            entry.data = ref_mem[row.ic_addr];
            exp_q.push_back(entry);
        end else if (dc_acc && (row.dc_type == WRITE)) begin
            ref_mem[row.dc_addr] = data;    // Writes give no response
        end else if (dc_acc) begin
            entry.tag  = DCACHE;
            entry.data = ref_mem[row.dc_addr];
            exp_q.push_back(entry);
        end
    endtask

    // Entered 1 ns after an edge, returns 1 ns after the next one
    task automatic run_cycle(input row_t row, input block_data_t data,
                             output logic ic_acc, output logic dc_acc);
        exp_resp_t head;
        logic      due_now;
        icache_req_valid      = row.ic_valid;
        icache_req_block_addr = row.ic_addr;
        dcache_req_valid      = row.dc_valid;
        dcache_req_type       = row.dc_type;
        dcache_req_block_addr = row.dc_addr;
        dcache_req_block_data = data;
        #2;                                 // Sample 1 ns before the edge
        ic_acc = row.ic_valid;
        dc_acc = row.dc_valid && !row.ic_valid;
        check_ready("icache_req_ready", icache_req_ready, ic_acc);
        check_ready("dcache_req_ready", dcache_req_ready, dc_acc);
        due_now = (exp_q.size() != 0) && (exp_q[0].due == cycle + 1);
        if (due_now) begin
            head = exp_q.pop_front();
            check_resp(1'b1, head.tag, head.data);
        end else begin
            check_resp(1'b0, ICACHE, '0);
        end
        @(posedge clk);
        cycle++;
        record_accept(row, data, ic_acc, dc_acc);
        #1;
    endtask

    // Columns: ic_valid ic_addr dc_valid dc_type dc_addr dc_rand
    task automatic load_table();
        rows[0]  = '{1'b0, 6'h00, 1'b0, READ,  6'h00, 1'b0};
        rows[1]  = '{1'b0, 6'h00, 1'b0, READ,  6'h00, 1'b0};
        rows[2]  = '{1'b0, 6'h00, 1'b1, WRITE, 6'h05, 1'b1};
        rows[3]  = '{1'b0, 6'h00, 1'b1, READ,  6'h05, 1'b0};   // Read right after write
        rows[4]  = '{1'b0, 6'h00, 1'b1, WRITE, 6'h11, 1'b1};
        rows[5]  = '{1'b0, 6'h00, 1'b1, WRITE, 6'h2a, 1'b1};
        rows[6]  = '{1'b0, 6'h00, 1'b1, WRITE, 6'h3f, 1'b1};
        rows[7]  = '{1'b1, 6'h11, 1'b1, WRITE, 6'h08, 1'b1};   // Both ask, dcache waits
        rows[8]  = '{1'b1, 6'h2a, 1'b1, READ,  6'h3f, 1'b0};
        rows[9]  = '{1'b1, 6'h05, 1'b0, READ,  6'h00, 1'b0};   // Back-to-back reads
        rows[10] = '{1'b0, 6'h00, 1'b1, READ,  6'h11, 1'b0};
        rows[11] = '{1'b1, 6'h3f, 1'b0, READ,  6'h00, 1'b0};
        rows[12] = '{1'b0, 6'h00, 1'b1, READ,  6'h2a, 1'b0};
        rows[13] = '{1'b1, 6'h08, 1'b0, READ,  6'h00, 1'b0};
        rows[14] = '{1'b0, 6'h00, 1'b1, READ,  6'h08, 1'b0};
        rows[15] = '{1'b1, 6'h05, 1'b0, READ,  6'h00, 1'b0};
        rows[16] = '{1'b0, 6'h00, 1'b1, READ,  6'h05, 1'b0};
        rows[17] = '{1'b0, 6'h00, 1'b1, WRITE, 6'h05, 1'b1};
        rows[18] = '{1'b1, 6'h05, 1'b0, READ,  6'h00, 1'b0};   // Sees the new block
        rows[19] = '{1'b0, 6'h00, 1'b1, READ,  6'h3f, 1'b0};
        rows[20] = '{1'b0, 6'h00, 1'b0, READ,  6'h00, 1'b0};
    endtask

    initial begin
        row_t        row;
        block_data_t data;
        logic        ic_acc;
        logic        dc_acc;
        int          tries;
        int          drain;
        rng_state             = 32'h69da_25d0;
        cycle                 = 0;
        rst_n                 = 1'b0;
        icache_req_valid      = 1'b0;
        icache_req_block_addr = '0;
        dcache_req_valid      = 1'b0;
        dcache_req_type       = READ;
        dcache_req_block_addr = '0;
        dcache_req_block_data = '0;
        load_table();

        // Three reset edges, outputs checked from the second on
        @(posedge clk);
        cycle++;
        #1;
        for (int i = 0; i < 2; i++) begin
            run_cycle('0, '0, ic_acc, dc_acc);
        end
        rst_n = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            row  = rows[r];
            data = row.dc_rand ? random_block() : '0;
            run_cycle(row, data, ic_acc, dc_acc);
            tries = 0;
            while (row.dc_valid && !dc_acc) begin
                if (tries >= HOLD_TIMEOUT) begin
                    abort_run($sformatf("dcache request of row %0d was never granted", r));
                end else begin
                    row.ic_valid = 1'b0;    // Icache part was already taken
                    run_cycle(row, data, ic_acc, dc_acc);
                    tries++;
                end
            end
        end

        drain = 0;
        while (exp_q.size() != 0) begin
            if (drain >= DRAIN_TIMEOUT) begin
                abort_run("expected responses were still missing after the drain timeout");
            end else begin
                run_cycle('0, '0, ic_acc, dc_acc);
                drain++;
            end
        end
        for (int i = 0; i < 3; i++) begin
            run_cycle('0, '0, ic_acc, dc_acc);    // No stray strobes once idle
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
source/mem_cfg_pkg.sv
source/mem_types_pkg.sv
source/mem_ctrl.sv
source/main_mem.sv
source/mem_resp_router.sv
source/mem_subsys.sv
verification/mem_subsys_chk.sv
verification/mem_subsys_tb.sv
